//--- soc_bus_pkg.sv
////////////////////////////////////////////////////////////
// System bus types for the 16-bit Wishbone subsystem
// Bus widths, the two-view address union and the
// request and response packets
////////////////////////////////////////////////////////////

package soc_bus_pkg;

  // Data word and byte lanes
  localparam int DATA_W = 16;
  localparam int SEL_W = DATA_W / 8;

  // Word address covers byte address bits 19 to 1
  localparam int ADDR_W = 19;
  localparam int REGION_W = 4;
  localparam int OFFSET_W = ADDR_W - REGION_W;

  // Memory space view of the word address
  typedef struct packed {
    logic [REGION_W-1:0] region;
    logic [OFFSET_W-1:0] offset;
  } mem_addr_t;

  // I/O space view, upper bits carry nothing
  typedef struct packed {
    logic [REGION_W-1:0] unused;
    logic [OFFSET_W-1:0] port;
  } io_addr_t;

  // Same address bits, decoded by tga
  typedef union packed {
    mem_addr_t mem;
    io_addr_t  io;
  } bus_addr_u;

  // Master request
  typedef struct packed {
    bus_addr_u         adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    logic              we;
    logic              tga;
    logic              stb;
    logic              cyc;
  } bus_req_t;

  // Slave response
  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
  } bus_rsp_t;

endpackage

//--- soc_map_pkg.sv
////////////////////////////////////////////////////////////
// Address map of the subsystem
// Memory regions, memory sizes, I/O port numbers,
// interrupt vector base and reset values
////////////////////////////////////////////////////////////

package soc_map_pkg;

  // Memory regions, 0 to 7 are SRAM, 8 to E unmapped
  localparam logic [3:0] REGION_ROM = 4'hF;
  localparam logic [3:0] REGION_SRAM_LAST = 4'h7;

  // Memory sizes in words
  localparam int ROM_WORDS = 32;
  localparam int ROM_AW = $clog2(ROM_WORDS);
  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_AW = $clog2(SRAM_WORDS);

  // Port word numbers (byte port shifted right by one)
  localparam logic [14:0] PORT_LED = 15'h7880;
  localparam logic [14:0] PORT_TIMER = 15'h0020;
  localparam logic [14:0] PORT_SOFTIRQ = 15'h0011;
  localparam logic [14:0] PORT_STATUS = 15'h0032;

  // Timer period after reset, in clock cycles
  localparam logic [15:0] TIMER_RESET_PERIOD = 16'd200;

  // Vector returned for line 0, line 1 follows
  localparam logic [15:0] IRQ_VECTOR_BASE = 16'h0008;

endpackage

//--- bus_decoder.sv
////////////////////////////////////////////////////////////
// Bus decoder
// Splits each cycle into ROM, SRAM, unmapped or I/O arena,
// gates the slave strobes and multiplexes ack and data
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_decoder (
  input  soc_bus_pkg::bus_req_t           bus_req_i,
  input  logic                            inta_i,
  output soc_bus_pkg::bus_req_t           rom_req_o,
  output soc_bus_pkg::bus_req_t           sram_req_o,
  output soc_bus_pkg::bus_req_t           io_req_o,
  input  soc_bus_pkg::bus_rsp_t           rom_rsp_i,
  input  soc_bus_pkg::bus_rsp_t           sram_rsp_i,
  input  soc_bus_pkg::bus_rsp_t           io_rsp_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]  vector_i,
  output logic                            iack_o,
  output soc_bus_pkg::bus_rsp_t           bus_rsp_o
);

  logic                             active;
  logic [soc_bus_pkg::REGION_W-1:0] region;
  logic                             mem_cycle;
  logic                             io_arena;
  logic                             rom_arena;
  logic                             sram_arena;
  logic                             unmapped_arena;

  assign active = bus_req_i.stb & bus_req_i.cyc;
  assign region = bus_req_i.adr.mem.region;

  // Acknowledge cycles are answered here and reach no slave
  assign mem_cycle = ~bus_req_i.tga & ~inta_i;
  assign io_arena = bus_req_i.tga & ~inta_i;
  assign rom_arena = mem_cycle & (region == soc_map_pkg::REGION_ROM);
  assign sram_arena = mem_cycle & (region <= soc_map_pkg::REGION_SRAM_LAST);
  assign unmapped_arena = mem_cycle & ~rom_arena & ~sram_arena;

  // Each slave sees the full request with its own strobe
  always_comb begin
    rom_req_o = bus_req_i;
    rom_req_o.stb = bus_req_i.stb & rom_arena;
    sram_req_o = bus_req_i;
    sram_req_o.stb = bus_req_i.stb & sram_arena;
    io_req_o = bus_req_i;
    io_req_o.stb = bus_req_i.stb & io_arena;
  end

  // Pending bit is cleared on the edge that ends this cycle
  assign iack_o = inta_i & active;

  always_comb begin
    bus_rsp_o = '0;
    if (inta_i) begin
      bus_rsp_o.ack = active;
      bus_rsp_o.dat = vector_i;
    end else if (io_arena) begin
      bus_rsp_o = io_rsp_i;
    end else if (rom_arena) begin
      bus_rsp_o = rom_rsp_i;
    end else if (sram_arena) begin
      bus_rsp_o = sram_rsp_i;
    end else if (unmapped_arena) begin
      // Unmapped memory reads as zero
      bus_rsp_o.ack = active;
    end
  end

endmodule

//--- boot_rom.sv
////////////////////////////////////////////////////////////
// Boot ROM slave
// 32-word array loaded from rom.hex, one wait state
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module boot_rom (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o
);

  logic                               active;
  logic [soc_map_pkg::ROM_AW-1:0]     index;
  logic                               wait_q;
  logic                               ack_q;
  logic [soc_bus_pkg::DATA_W-1:0]     dat_q;
  logic [soc_bus_pkg::DATA_W-1:0]     rom_mem [soc_map_pkg::ROM_WORDS];

  initial $readmemh("rom.hex", rom_mem);

  assign active = req_i.stb & req_i.cyc;
  // Offset wraps modulo the ROM size
  assign index = req_i.adr.mem.offset[soc_map_pkg::ROM_AW-1:0];

  // Strobe edge -> wait state -> ack, then idle while stb is still held
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q <= 1'b0;
      ack_q <= 1'b0;
    end else if (!active || ack_q) begin
      wait_q <= 1'b0;
      ack_q <= 1'b0;
    end else if (wait_q) begin
      wait_q <= 1'b0;
      ack_q <= 1'b1;
    end else begin
      wait_q <= 1'b1;
    end
  end

  // Word is fetched alongside the ack, writes fall through unused
  always_ff @(posedge clk) begin
    if (active && wait_q) begin
      dat_q <= rom_mem[index];
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = dat_q;

endmodule

//--- sram_slave.sv
////////////////////////////////////////////////////////////
// SRAM slave
// 1024 words with byte lane writes and a registered ack
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_slave (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o
);

  logic                            active;
  logic                            start;
  logic [soc_map_pkg::SRAM_AW-1:0] index;
  logic                            ack_q;
  logic [soc_bus_pkg::DATA_W-1:0]  dat_q;
  logic [soc_bus_pkg::DATA_W-1:0]  mem [soc_map_pkg::SRAM_WORDS];

  assign active = req_i.stb & req_i.cyc;
  // First edge of a strobe, ack blocks a second one
  assign start = active & ~ack_q;
  assign index = req_i.adr.mem.offset[soc_map_pkg::SRAM_AW-1:0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      if (req_i.we) begin
        for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
          if (req_i.sel[b]) begin
            mem[index][b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end else begin
        dat_q <= mem[index];
      end
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = dat_q;

endmodule

//--- io_ports.sv
////////////////////////////////////////////////////////////
// I/O port block
// LED and timer period registers, software interrupt
// port and interrupt status port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module io_ports (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  input  logic [1:0]            pending_i,
  output logic [15:0]           period_o,
  output logic                  period_load_o,
  output logic                  soft_irq_o,
  output logic [15:0]           led_o
);

  logic                             active;
  logic                             wr;
  logic [soc_bus_pkg::OFFSET_W-1:0] port;
  logic [15:0]                      led_q;
  logic [15:0]                      period_q;
  logic                             load_q;

  assign active = req_i.stb & req_i.cyc;
  assign wr = active & req_i.we;
  assign port = req_i.adr.io.port;

  // Ports are word wide, sel is not decoded
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      led_q <= '0;
      period_q <= soc_map_pkg::TIMER_RESET_PERIOD;
      load_q <= 1'b0;
    end else begin
      load_q <= wr && (port == soc_map_pkg::PORT_TIMER);
      if (wr && port == soc_map_pkg::PORT_LED) begin
        led_q <= req_i.dat;
      end
      if (wr && port == soc_map_pkg::PORT_TIMER) begin
        period_q <= req_i.dat;
      end
    end
  end

  // Load trails the write so the timer sees the new period
  assign period_load_o = load_q;
  assign period_o = period_q;
  assign led_o = led_q;
  assign soft_irq_o = wr && (port == soc_map_pkg::PORT_SOFTIRQ);

  always_comb begin
    rsp_o.ack = active;
    case (port)
      soc_map_pkg::PORT_LED:    rsp_o.dat = led_q;
      soc_map_pkg::PORT_TIMER:  rsp_o.dat = period_q;
      soc_map_pkg::PORT_STATUS: rsp_o.dat = {14'b0, pending_i};
      default:                  rsp_o.dat = '0;
    endcase
  end

endmodule

//--- tick_timer.sv
////////////////////////////////////////////////////////////
// Periodic tick timer
// Down-counter with reload, one pulse per period
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tick_timer (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic [15:0] period_i,
  input  logic        load_i,
  output logic        tick_o
);

  logic [15:0] count_q;
  logic        zero;

  assign zero = (count_q == '0);

  // Counts period-1 down to 0, so one tick every period cycles
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= soc_map_pkg::TIMER_RESET_PERIOD - 16'd1;
    end else if (load_i || zero) begin
      count_q <= period_i - 16'd1;
    end else begin
      count_q <= count_q - 16'd1;
    end
  end

  assign tick_o = zero;

endmodule

//--- irq_ctrl.sv
////////////////////////////////////////////////////////////
// Two-line interrupt controller
// Pending latch, fixed priority and acknowledge vector
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module irq_ctrl (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic [1:0]  irq_i,
  input  logic        iack_i,
  output logic        intr_o,
  output logic [15:0] vector_o,
  output logic [1:0]  pending_o
);

  logic [1:0] pending_q;
  logic       iid;
  logic [1:0] clear;

  // Line 0 wins over line 1
  assign iid = ~pending_q[0];

  always_comb begin
    clear = '0;
    if (iack_i) begin
      clear[iid] = 1'b1;
    end
  end

  // New requests are ORed in after the clear
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clear) | irq_i;
    end
  end

  assign intr_o = |pending_q;
  assign vector_o = soc_map_pkg::IRQ_VECTOR_BASE + {15'b0, iid};
  assign pending_o = pending_q;

endmodule

//--- soc_top.sv
////////////////////////////////////////////////////////////
// Subsystem top level
// Decoder, ROM, SRAM, port block, timer and interrupt
// controller on one Wishbone bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_top (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  soc_bus_pkg::bus_req_t bus_req_i,
  input  logic                  inta_i,
  output soc_bus_pkg::bus_rsp_t bus_rsp_o,
  output logic                  intr_o,
  output logic [15:0]           led_o
);

  soc_bus_pkg::bus_req_t rom_req;
  soc_bus_pkg::bus_req_t sram_req;
  soc_bus_pkg::bus_req_t io_req;
  soc_bus_pkg::bus_rsp_t rom_rsp;
  soc_bus_pkg::bus_rsp_t sram_rsp;
  soc_bus_pkg::bus_rsp_t io_rsp;
  logic [15:0]           vector;
  logic                  iack;
  logic [1:0]            pending;
  logic [15:0]           period;
  logic                  period_load;
  logic                  soft_irq;
  logic                  tick;

  bus_decoder u_bus_decoder (
    .bus_req_i  (bus_req_i),
    .inta_i     (inta_i),
    .rom_req_o  (rom_req),
    .sram_req_o (sram_req),
    .io_req_o   (io_req),
    .rom_rsp_i  (rom_rsp),
    .sram_rsp_i (sram_rsp),
    .io_rsp_i   (io_rsp),
    .vector_i   (vector),
    .iack_o     (iack),
    .bus_rsp_o  (bus_rsp_o)
  );

  boot_rom u_boot_rom (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (rom_req),
    .rsp_o    (rom_rsp)
  );

  sram_slave u_sram_slave (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (sram_req),
    .rsp_o    (sram_rsp)
  );

  io_ports u_io_ports (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .req_i         (io_req),
    .rsp_o         (io_rsp),
    .pending_i     (pending),
    .period_o      (period),
    .period_load_o (period_load),
    .soft_irq_o    (soft_irq),
    .led_o         (led_o)
  );

  tick_timer u_tick_timer (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .period_i (period),
    .load_i   (period_load),
    .tick_o   (tick)
  );

  // Line 0 is the timer, line 1 the software port
  irq_ctrl u_irq_ctrl (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .irq_i     ({soft_irq, tick}),
    .iack_i    (iack),
    .intr_o    (intr_o),
    .vector_o  (vector),
    .pending_o (pending)
  );

endmodule

//--- tb_soc_model.svh
////////////////////////////////////////////////////////////
// Reference model for the subsystem testbench
// ROM and SRAM images, port values, expected pending bits
// and the typed compare tasks
////////////////////////////////////////////////////////////

  logic [soc_bus_pkg::DATA_W-1:0] rom_model [soc_map_pkg::ROM_WORDS];
  logic [soc_bus_pkg::DATA_W-1:0] sram_model [soc_map_pkg::SRAM_WORDS];
  logic [15:0]                    led_model;
  logic [15:0]                    period_model;
  logic [1:0]                     pending_model;
  int                             mismatch_count = 0;
  int                             other_count = 0;

  initial $readmemh("rom.hex", rom_model);

  // ROM and SRAM both wrap the offset at their size
  function automatic logic [15:0] rom_word(input logic [14:0] offset);
    return rom_model[offset % soc_map_pkg::ROM_WORDS];
  endfunction

  function automatic int sram_index(input logic [14:0] offset);
    return offset % soc_map_pkg::SRAM_WORDS;
  endfunction

  // Byte lanes without a sel bit keep their old contents
  task automatic sram_merge(input logic [14:0] offset, input logic [15:0] data,
                            input logic [1:0] sel);
    int idx;
    idx = sram_index(offset);
    if (sel[0]) begin
      sram_model[idx][7:0] = data[7:0];
    end
    if (sel[1]) begin
      sram_model[idx][15:8] = data[15:8];
    end
  endtask

  task automatic check_word(input string name, input logic [soc_bus_pkg::DATA_W-1:0] exp,
                            input logic [soc_bus_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_rsp(input string name, input soc_bus_pkg::bus_rsp_t exp,
                           input soc_bus_pkg::bus_rsp_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected dat=%h ack=%b, actual dat=%h ack=%b",
               name, exp.dat, exp.ack, act.dat, act.ack);
      mismatch_count++;
    end
  endtask

  task automatic check_pending(input string name, input logic [1:0] exp,
                               input logic [1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      mismatch_count++;
    end
  endtask

//--- tb_soc_top.sv
////////////////////////////////////////////////////////////
// Testbench for the bus subsystem
// Clock, reset, random bus master, interrupt acknowledge
// sequences and the closing result line
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_soc_top;

  logic                  clk;
  logic                  arst_n;
  soc_bus_pkg::bus_req_t bus_req;
  logic                  inta;
  soc_bus_pkg::bus_rsp_t bus_rsp;
  logic                  intr;
  logic [15:0]           led;

  `include "tb_soc_model.svh"

  soc_top u_soc_top (
    .clk       (clk),
    .arst_n_i  (arst_n),
    .bus_req_i (bus_req),
    .inta_i    (inta),
    .bus_rsp_o (bus_rsp),
    .intr_o    (intr),
    .led_o     (led)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Holds one cycle until ack is seen at a falling edge and then idles
  task automatic run_cycle(input soc_bus_pkg::bus_req_t req, input logic ack_cycle,
                           input string name, output soc_bus_pkg::bus_rsp_t rsp);
    int waited;
    waited = 0;
    rsp = '0;
    req.stb = 1'b1;
    req.cyc = 1'b1;
    @(posedge clk);
    bus_req <= req;
    inta <= ack_cycle;
    @(negedge clk);
    while (!bus_rsp.ack && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (bus_rsp.ack) begin
      rsp = bus_rsp;
    end else begin
      $display("%s: no ack from the bus within 20 cycles", name);
      other_count++;
    end
    @(posedge clk);
    bus_req <= '0;
    inta <= 1'b0;
    @(negedge clk);
  endtask

  task automatic write_mem(input logic [3:0] region, input logic [14:0] offset,
                           input logic [15:0] data, input logic [1:0] sel);
    soc_bus_pkg::bus_req_t req;
    soc_bus_pkg::bus_rsp_t rsp;
    req = '0;
    req.adr.mem.region = region;
    req.adr.mem.offset = offset;
    req.dat = data;
    req.sel = sel;
    req.we = 1'b1;
    run_cycle(req, 1'b0, "memory write", rsp);
  endtask

  task automatic read_mem(input logic [3:0] region, input logic [14:0] offset,
                          output logic [15:0] data);
    soc_bus_pkg::bus_req_t req;
    soc_bus_pkg::bus_rsp_t rsp;
    req = '0;
    req.adr.mem.region = region;
    req.adr.mem.offset = offset;
    req.sel = 2'b11;
    run_cycle(req, 1'b0, "memory read", rsp);
    data = rsp.dat;
  endtask

  // Random upper address bits, ignored by the port view
  task automatic write_port(input logic [14:0] port, input logic [15:0] data);
    soc_bus_pkg::bus_req_t req;
    soc_bus_pkg::bus_rsp_t rsp;
    req = '0;
    req.adr.io.unused = 4'($urandom);
    req.adr.io.port = port;
    req.dat = data;
    req.sel = 2'b11;
    req.we = 1'b1;
    req.tga = 1'b1;
    run_cycle(req, 1'b0, "port write", rsp);
  endtask

  task automatic read_port(input logic [14:0] port, output logic [15:0] data);
    soc_bus_pkg::bus_req_t req;
    soc_bus_pkg::bus_rsp_t rsp;
    req = '0;
    req.adr.io.unused = 4'($urandom);
    req.adr.io.port = port;
    req.sel = 2'b11;
    req.tga = 1'b1;
    run_cycle(req, 1'b0, "port read", rsp);
    data = rsp.dat;
  endtask

  task automatic acknowledge_irq(output soc_bus_pkg::bus_rsp_t rsp);
    soc_bus_pkg::bus_req_t req;
    req = '0;
    run_cycle(req, 1'b1, "interrupt acknowledge", rsp);
  endtask

  task automatic wait_for_intr(input int limit);
    int waited;
    waited = 0;
    while (!intr && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!intr) begin
      $display("intr_o did not rise within %0d cycles", limit);
      other_count++;
    end
  endtask

  // Clears ticks left over from earlier tests
  task automatic drain_irqs();
    soc_bus_pkg::bus_rsp_t rsp;
    int rounds;
    rounds = 0;
    while (intr && rounds < 4) begin
      acknowledge_irq(rsp);
      rounds++;
    end
    if (intr) begin
      $display("intr_o still high after %0d acknowledge cycles", rounds);
      other_count++;
    end
  endtask

  function automatic logic is_known_port(input logic [14:0] port);
    return port == soc_map_pkg::PORT_LED || port == soc_map_pkg::PORT_TIMER ||
           port == soc_map_pkg::PORT_SOFTIRQ || port == soc_map_pkg::PORT_STATUS;
  endfunction

  initial begin
    soc_bus_pkg::bus_rsp_t rsp;
    soc_bus_pkg::bus_rsp_t exp_rsp;
    logic [15:0]           data;
    logic [15:0]           wdata;
    logic [14:0]           offset;
    logic [3:0]            region;
    logic [1:0]            sel;
    logic [14:0]           port;
    logic [14:0]           written [$];
    void'($urandom(32'h10db_9165));
    arst_n = 1'b0;
    bus_req = '0;
    inta = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_flag("reset intr_o", 1'b0, intr);
    check_flag("reset ack", 1'b0, bus_rsp.ack);
    check_word("reset led_o", 16'h0000, led);
    read_port(soc_map_pkg::PORT_TIMER, data);
    check_word("reset period", soc_map_pkg::TIMER_RESET_PERIOD, data);

    // Boot ROM reads and writes that must not stick
    for (int i = 0; i < 40; i++) begin
      offset = 15'($urandom);
      read_mem(soc_map_pkg::REGION_ROM, offset, data);
      check_word("rom read", rom_word(offset), data);
    end
    for (int i = 0; i < 20; i++) begin
      offset = 15'($urandom);
      wdata = 16'($urandom);
      write_mem(soc_map_pkg::REGION_ROM, offset, wdata, 2'b11);
      read_mem(soc_map_pkg::REGION_ROM, offset, data);
      check_word("rom after write", rom_word(offset), data);
    end

    // SRAM writes with random byte selects and reads of written words
    for (int i = 0; i < 300; i++) begin
      region = 4'($urandom_range(7, 0));
      offset = 15'($urandom);
      wdata = 16'($urandom);
      sel = 2'($urandom);
      write_mem(region, offset, wdata, sel);
      sram_merge(offset, wdata, sel);
      written.push_back(offset);
      if ($urandom_range(1, 0) == 1) begin
        offset = written[$urandom_range(written.size() - 1, 0)];
        read_mem(4'($urandom_range(7, 0)), offset, data);
        check_word("sram read", sram_model[sram_index(offset)], data);
      end
    end

    // Unmapped regions read zero and disturb no SRAM word
    for (int i = 0; i < 20; i++) begin
      region = 4'($urandom_range(14, 8));
      offset = written[$urandom_range(written.size() - 1, 0)];
      wdata = 16'($urandom);
      write_mem(region, offset, wdata, 2'b11);
      read_mem(region, offset, data);
      check_word("unmapped read", 16'h0000, data);
      read_mem(4'($urandom_range(7, 0)), offset, data);
      check_word("sram after unmapped write", sram_model[sram_index(offset)], data);
    end

    for (int i = 0; i < 10; i++) begin
      wdata = 16'($urandom);
      write_port(soc_map_pkg::PORT_LED, wdata);
      led_model = wdata;
      check_word("led_o", led_model, led);
      read_port(soc_map_pkg::PORT_LED, data);
      check_word("led readback", led_model, data);
      wdata = 16'($urandom);
      write_port(soc_map_pkg::PORT_TIMER, wdata);
      period_model = wdata;
      read_port(soc_map_pkg::PORT_TIMER, data);
      check_word("period readback", period_model, data);
      port = 15'($urandom);
      while (is_known_port(port)) begin
        port = 15'($urandom);
      end
      read_port(port, data);
      check_word("unknown port", 16'h0000, data);
    end

    // Software interrupt with the timer slowed right down
    write_port(soc_map_pkg::PORT_TIMER, 16'hFFFF);
    repeat (2) @(negedge clk);
    drain_irqs();
    pending_model = 2'b00;
    read_port(soc_map_pkg::PORT_STATUS, data);
    check_pending("status idle", pending_model, data[1:0]);
    write_port(soc_map_pkg::PORT_SOFTIRQ, 16'h0001);
    pending_model = 2'b10;
    check_flag("intr_o after soft write", 1'b1, intr);
    read_port(soc_map_pkg::PORT_STATUS, data);
    check_pending("status soft", pending_model, data[1:0]);
    acknowledge_irq(rsp);
    exp_rsp.dat = soc_map_pkg::IRQ_VECTOR_BASE + 16'd1;
    exp_rsp.ack = 1'b1;
    check_rsp("soft vector", exp_rsp, rsp);
    pending_model = 2'b00;
    check_flag("intr_o after soft ack", 1'b0, intr);

    // Timer tick plus soft request with line 0 served first
    write_port(soc_map_pkg::PORT_TIMER, 16'd40);
    wait_for_intr(80);
    write_port(soc_map_pkg::PORT_TIMER, 16'hFFFF);
    repeat (2) @(negedge clk);
    write_port(soc_map_pkg::PORT_SOFTIRQ, 16'h0001);
    pending_model = 2'b11;
    read_port(soc_map_pkg::PORT_STATUS, data);
    check_pending("status both", pending_model, data[1:0]);
    acknowledge_irq(rsp);
    exp_rsp.dat = soc_map_pkg::IRQ_VECTOR_BASE;
    check_rsp("timer vector", exp_rsp, rsp);
    pending_model = 2'b10;
    acknowledge_irq(rsp);
    exp_rsp.dat = soc_map_pkg::IRQ_VECTOR_BASE + 16'd1;
    check_rsp("soft vector after timer", exp_rsp, rsp);
    pending_model = 2'b00;
    check_flag("intr_o after both acks", 1'b0, intr);
    read_port(soc_map_pkg::PORT_STATUS, data);
    check_pending("status cleared", pending_model, data[1:0]);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+.
soc_bus_pkg.sv
soc_map_pkg.sv
bus_decoder.sv
boot_rom.sv
sram_slave.sv
io_ports.sv
tick_timer.sv
irq_ctrl.sv
soc_top.sv
tb_soc_top.sv

//--- rom.hex
// One 16-bit hex word per line, ROM words 0 to 31 in order
FA1C
0B3E
7D42
C8E1
2F90
5A0D
91B7
E36C
4C25
08FF
B7D3
6E41
13A8
D05E
87C2
3B19
A4F6
5D8A
F2E3
2071
9C4B
46D0
E817
7B65
0DAC
C39F
6128
B5E4
1F7A
8A03
54C9
DE36
